// File: compile.f
+incdir+common
common/splitter_pkg.sv
splitter/splitter.sv
logic/spill_mem.sv
logic/splitter_regs.sv
logic/splitter_top.sv
testbench/splitter_props.sv
testbench/splitter_checker.sv
testbench/splitter_tb.sv

// File: Bender.yml
package:
  name: splitter

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/splitter_pkg.sv
      - splitter/splitter.sv
      - logic/spill_mem.sv
      - logic/splitter_regs.sv
      - logic/splitter_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/splitter_props.sv
      - testbench/splitter_checker.sv
      - testbench/splitter_tb.sv

// File: testbench/splitter_tb.sv
`timescale 1ns/1ps
`include "splitter_config.svh"

module splitter_tb import splitter_pkg::*; ();

   localparam int        NUM_TASKS    = 120;
   localparam int        NUM_IDS      = 32;
   localparam int        LIMIT        = 400; // cycles per wait.
   localparam int        STACK_TOP    = 64;
   localparam mem_addr_t BASE_TASKS   = 10'd0;
   localparam mem_addr_t BASE_SCRATCH = 10'd256;
   localparam mem_addr_t BASE_STACK   = 10'd512;
   localparam mem_addr_t PTR_ADDR     = 10'd768;

   logic      clk, rstn;
   logic      in_valid, in_ready, out_valid, out_ready;
   task_t     in_task, out_task;
   logic      lock_in, lock_out;
   logic      host_valid, host_rvalid;
   host_req_t host_req;
   mem_word_t host_rdata;
   ts_t       lvt;
   logic      run_done;
   int        errors, checks, pushes;
   int        timeouts = 0;

   splitter_top DUT (.*);

   splitter_checker u_checker (
      .clk, .rstn, .in_valid, .in_ready, .in_task, .out_valid, .out_ready, .out_task,
      .lock_in, .lock_out, .host_valid, .host_req, .host_rvalid, .host_rdata, .lvt,
      .state(DUT.state), .run_done, .errors, .checks, .pushes
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic finish_run();
      int prop_fails;
      prop_fails = DUT.u_splitter.u_props.fails;
      $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
               checks, errors, timeouts, prop_fails);
      if (errors == 0 && timeouts == 0 && prop_fails == 0) $display("all tests passed");
      else $display("tests failed");
      $finish;
   endtask

   task automatic give_up(string what);
      timeouts++;
      $display("timed out at %0t waiting for %s", $time, what);
      finish_run();
   endtask

   task automatic host_write(logic sel_mem, mem_addr_t addr, mem_word_t data);
      host_valid = 1'b1;
      host_req   = '{write: 1'b1, sel_mem: sel_mem, addr: addr, wdata: data};
      @(posedge clk);
      #1;
      host_valid = 1'b0;
   endtask

   task automatic host_read(logic sel_mem, mem_addr_t addr);
      int n;
      host_valid = 1'b1;
      host_req   = '{write: 1'b0, sel_mem: sel_mem, addr: addr, wdata: '0};
      @(posedge clk);
      #1;
      host_valid = 1'b0;
      n = 0;
      while (!host_rvalid) begin
         if (n == 8) give_up("a host read response");
         @(posedge clk);
         #1;
         n++;
      end
   endtask

   function automatic task_t random_task();
      task_t t;
      t.ttype  = 4'($urandom);
      t.ts     = ts_t'($urandom) & 28'h7ff_ffff; // never all ones.
      t.locale = {16'($urandom_range(0, NUM_IDS - 1)), 16'($urandom)};
      return t;
   endfunction

   // sample in_ready at the falling edge since it follows in_valid.
   task automatic offer_task(task_t t);
      int n;
      in_valid = 1'b1;
      in_task  = t;
      n = 0;
      @(negedge clk);
      while (!in_ready) begin
         if (n == LIMIT) give_up("in_ready");
         @(negedge clk);
         n++;
      end
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   // consumer stalls and coalescer lock traffic.
   initial begin
      forever begin
         @(posedge clk);
         #1;
         out_ready = ($urandom_range(0, 3) != 0);
         lock_in   = lock_out ? 1'b0 : ($urandom_range(0, 3) == 0);
      end
   end

   initial begin
      int i;
      int n;
      void'($urandom(79));
      rstn       = 1'b0;
      in_valid   = 1'b0;
      in_task    = '0;
      out_ready  = 1'b0;
      lock_in    = 1'b0;
      host_valid = 1'b0;
      host_req   = '0;
      run_done   = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      rstn = 1'b1;

      in_valid = 1'b1; // must be ignored before start.
      in_task  = random_task();
      repeat (8) @(posedge clk);
      #1;
      in_valid = 1'b0;

      // ~~~~~~~~~~~~~~~~~~~~
      // memory image and configuration.
      for (i = 0; i < NUM_IDS * `SPL_TASKS_PER_SPLITTER; i++) begin
         host_write(1'b1, mem_addr_t'(BASE_TASKS + i), {$urandom, $urandom});
      end
      for (i = 0; i < NUM_IDS >> `SPL_LOG_PER_CHUNK; i++) begin
         host_write(1'b1, mem_addr_t'(BASE_SCRATCH + i), '0);
      end
      host_write(1'b1, PTR_ADDR, mem_word_t'(STACK_TOP));
      host_write(1'b0, `SPL_REG_BASE_TASKS, mem_word_t'(BASE_TASKS));
      host_write(1'b0, `SPL_REG_BASE_SCRATCH, mem_word_t'(BASE_SCRATCH));
      host_write(1'b0, `SPL_REG_BASE_STACK, mem_word_t'(BASE_STACK));
      host_write(1'b0, `SPL_REG_STACK_PTR, mem_word_t'(PTR_ADDR));
      host_write(1'b0, `SPL_REG_START, 64'd1);

      for (i = 0; i < NUM_TASKS; i++) begin
         n = $urandom_range(0, 6);
         repeat (n) begin
            @(posedge clk);
            #1;
         end
         offer_task(random_task());
      end
      n = 0;
      while (lvt !== '1) begin
         if (n == LIMIT) give_up("the splitter to go idle");
         @(posedge clk);
         #1;
         n++;
      end

      // ~~~~~~~~~~~~~~~~~~~~
      // readback.
      host_read(1'b0, `SPL_REG_NUM_DEQ);
      host_read(1'b0, `SPL_REG_NUM_ENQ);
      host_read(1'b0, `SPL_REG_STATE);
      for (i = 0; i < NUM_IDS >> `SPL_LOG_PER_CHUNK; i++) begin
         host_read(1'b1, mem_addr_t'(BASE_SCRATCH + i));
      end
      host_read(1'b1, PTR_ADDR);
      for (i = 0; i < pushes; i++) begin
         host_read(1'b1, mem_addr_t'(BASE_STACK + STACK_TOP - 1 - i));
      end
      run_done = 1'b1;
      @(posedge clk);
      #1;
      finish_run();
   end

endmodule

// File: testbench/splitter_checker.sv
`timescale 1ns/1ps
`include "splitter_config.svh"

module splitter_checker import splitter_pkg::*; (
   input  logic       clk,
   input  logic       rstn,
   input  logic       in_valid,
   input  logic       in_ready,
   input  task_t      in_task,
   input  logic       out_valid,
   input  logic       out_ready,
   input  task_t      out_task,
   input  logic       lock_in,
   input  logic       lock_out,
   input  logic       host_valid,
   input  host_req_t  host_req,
   input  logic       host_rvalid,
   input  mem_word_t  host_rdata,
   input  ts_t        lvt,
   input  spl_state_t state,
   input  logic       run_done,
   output int         errors,
   output int         checks,
   output int         pushes
);

   mem_word_t model [1 << `SPL_MEM_AW];
   mem_word_t child_q [$];
   mem_addr_t base_tasks, base_scratch, base_stack, ptr_addr;
   mem_word_t rd_exp;
   logic      rd_pend = 1'b0;
   logic      started = 1'b0;
   logic      prev_idle = 1'b0;
   logic      prev_rstn = 1'b0;
   logic      prev_lock_out = 1'b0;
   logic      prev_lock_in = 1'b0;
   ts_t       cur_ts;
   int        accepted = 0;

   initial begin
      errors = 0;
      checks = 0;
      pushes = 0;
   end

   task automatic compare(string what, mem_word_t got, mem_word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   function automatic mem_word_t host_expect(host_req_t r);
      if (r.sel_mem) return model[r.addr];
      case (r.addr[7:0])
         `SPL_REG_START:   return mem_word_t'(started);
         `SPL_REG_NUM_ENQ: return mem_word_t'(accepted * `SPL_TASKS_PER_SPLITTER);
         `SPL_REG_NUM_DEQ: return mem_word_t'(accepted);
         `SPL_REG_STATE:   return mem_word_t'(SPL_IDLE);
         default:          return 'x;
      endcase
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~
   // model of one accepted task.
   task automatic accept_task(task_t t);
      coal_id_t  id;
      mem_addr_t sa;
      mem_addr_t sp;
      mem_word_t word;
      int        k;
      id = t.locale[31:16];
      for (k = 0; k < `SPL_TASKS_PER_SPLITTER; k++) begin
         child_q.push_back(model[mem_addr_t'(base_tasks + id * `SPL_TASKS_PER_SPLITTER + k)]);
      end
      sa   = mem_addr_t'(base_scratch + (id >> `SPL_LOG_PER_CHUNK));
      word = model[sa] | (mem_word_t'(1) << id[`SPL_LOG_PER_CHUNK-1:0]);
      if (&word[(1 << `SPL_LOG_PER_CHUNK)-1:0]) begin // chunk full, push it.
         model[sa] = '0;
         sp = mem_addr_t'(model[ptr_addr]) - 1'b1;
         model[ptr_addr] = mem_word_t'(sp);
         model[mem_addr_t'(base_stack + sp)] = mem_word_t'(id >> `SPL_LOG_PER_CHUNK);
         pushes++;
      end else begin
         model[sa] = word;
      end
      cur_ts = t.ts;
      accepted++;
   endtask

   always @(posedge clk) begin
      if (rstn && prev_rstn) begin
         if (in_ready && !started) begin
            errors++;
            $display("in_ready went high at %0t before start was written", $time);
         end
         if (state != SPL_IDLE) compare("lvt", lvt, cur_ts);
         else if (prev_idle) compare("lvt in idle", lvt, ts_t'('1));
         if (lock_out && !prev_lock_out && prev_lock_in) begin
            errors++;
            $display("lock_out rose at %0t while the coalescer held the lock", $time);
         end
         if (rd_pend !== host_rvalid) begin
            errors++;
            $display("host_rvalid at %0t does not follow a read strobe", $time);
         end else if (rd_pend) begin
            compare("host read data", host_rdata, rd_exp);
         end
         if (out_valid && out_ready) begin
            if (child_q.size() == 0) begin
               errors++;
               $display("child task %h at %0t was never expected", out_task, $time);
            end else begin
               compare("child task", out_task, child_q.pop_front());
            end
         end
         if (in_valid && in_ready) accept_task(in_task);
      end
      rd_pend = host_valid && !host_req.write;
      if (rd_pend) rd_exp = host_expect(host_req);
      if (host_valid && host_req.write) begin
         if (host_req.sel_mem) begin
            model[host_req.addr] = host_req.wdata;
         end else begin
            case (host_req.addr[7:0])
               `SPL_REG_START:        started = host_req.wdata[0];
               `SPL_REG_BASE_TASKS:   base_tasks = host_req.wdata[`SPL_MEM_AW-1:0];
               `SPL_REG_BASE_SCRATCH: base_scratch = host_req.wdata[`SPL_MEM_AW-1:0];
               `SPL_REG_BASE_STACK:   base_stack = host_req.wdata[`SPL_MEM_AW-1:0];
               `SPL_REG_STACK_PTR:    ptr_addr = host_req.wdata[`SPL_MEM_AW-1:0];
               default: ;
            endcase
         end
      end
      prev_idle     = (state == SPL_IDLE);
      prev_rstn     = rstn;
      prev_lock_out = lock_out;
      prev_lock_in  = lock_in;
   end

   always @(posedge run_done) begin
      if (child_q.size() != 0) begin
         errors++;
         $display("%0d child tasks never came out", child_q.size());
      end
      if (lock_out !== 1'b0) begin
         errors++;
         $display("lock_out is still high at the end of the run");
      end
   end

endmodule

// File: testbench/splitter_props.sv
`timescale 1ns/1ps

module splitter_props import splitter_pkg::*; (
   input  logic       clk,
   input  logic       rstn,
   input  logic       lock_in,
   input  logic       lock_out,
   input  logic       out_valid,
   input  logic       out_ready,
   input  task_t      out_task,
   input  logic       req_valid,
   input  spl_state_t state
);

   int fails = 0;

   // lock is taken only while the coalescer is out.
   lock_rise: assert property (@(posedge clk) disable iff (!rstn)
      $rose(lock_out) |-> !$past(lock_in))
      else begin
         fails++;
         $error("lock_out rose while lock_in was high");
      end

   out_hold: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out_task))
      else begin
         fails++;
         $error("out_task changed during a stall");
      end

   idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
      state == SPL_IDLE |-> !req_valid)
      else begin
         fails++;
         $error("memory request raised in idle");
      end

endmodule

bind splitter splitter_props u_props (
   .clk(clk), .rstn(rstn), .lock_in(lock_in), .lock_out(lock_out),
   .out_valid(out_valid), .out_ready(out_ready), .out_task(out_task),
   .req_valid(req_valid), .state(state)
);

// File: logic/splitter_top.sv
`timescale 1ns/1ps

module splitter_top import splitter_pkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  logic      in_valid,
   output logic      in_ready,
   input  task_t     in_task,
   output logic      out_valid,
   input  logic      out_ready,
   output task_t     out_task,
   input  logic      lock_in,
   output logic      lock_out,
   input  logic      host_valid,
   input  host_req_t host_req,
   output logic      host_rvalid,
   output mem_word_t host_rdata,
   output ts_t       lvt
);

   cfg_t       cfg;
   spl_state_t state;
   logic       deq_fire, enq_fire;
   logic       req_valid, req_ready, rsp_valid, rsp_ready, wr_ack;
   mem_req_t   req;
   mem_rsp_t   rsp;
   logic       mem_en, mem_we;
   mem_addr_t  mem_addr;
   mem_word_t  mem_wdata, mem_rdata;

   splitter u_splitter (
      .clk, .rstn, .cfg,
      .in_valid, .in_ready, .in_task,
      .out_valid, .out_ready, .out_task,
      .req_valid, .req_ready, .req, .rsp_valid, .rsp_ready, .rsp, .wr_ack,
      .lock_in, .lock_out, .lvt, .state, .deq_fire, .enq_fire
   );

   spill_mem u_spill_mem (
      .clk, .rstn,
      .req_valid, .req_ready, .req, .rsp_valid, .rsp_ready, .rsp, .wr_ack,
      .host_en(mem_en), .host_we(mem_we), .host_addr(mem_addr),
      .host_wdata(mem_wdata), .host_rdata(mem_rdata)
   );

   splitter_regs #(.core_id(0)) u_regs (
      .clk, .rstn, .host_valid, .host_req, .host_rvalid, .host_rdata,
      .cfg, .state, .deq_fire, .enq_fire,
      .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
   );

endmodule

// File: logic/splitter_regs.sv
`timescale 1ns/1ps
`include "splitter_config.svh"

module splitter_regs import splitter_pkg::*; #(
   parameter int core_id = 0
) (
   input  logic       clk,
   input  logic       rstn,
   input  logic       host_valid,
   input  host_req_t  host_req,
   output logic       host_rvalid,
   output mem_word_t  host_rdata,
   output cfg_t       cfg,
   input  spl_state_t state,
   input  logic       deq_fire,
   input  logic       enq_fire,
   output logic       mem_en,
   output logic       mem_we,
   output mem_addr_t  mem_addr,
   output mem_word_t  mem_wdata,
   input  mem_word_t  mem_rdata
);

   logic [31:0] num_enq, num_deq;
   logic        reg_wr;
   logic        rd_mem_q;
   mem_word_t   reg_rdata;

   // memory accesses pass straight through.
   assign mem_en    = host_valid & host_req.sel_mem;
   assign mem_we    = host_req.write;
   assign mem_addr  = host_req.addr;
   assign mem_wdata = host_req.wdata;
   assign reg_wr    = host_valid & ~host_req.sel_mem & host_req.write;

   assign host_rdata = rd_mem_q ? mem_rdata : reg_rdata;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cfg     <= '0;
         num_enq <= '0;
         num_deq <= '0;
      end else begin
         if (reg_wr) begin
            case (host_req.addr[7:0])
               `SPL_REG_START:        cfg.start <= host_req.wdata[core_id];
               `SPL_REG_BASE_TASKS:   cfg.base_tasks <= host_req.wdata[`SPL_MEM_AW-1:0];
               `SPL_REG_BASE_SCRATCH: cfg.base_scratch <= host_req.wdata[`SPL_MEM_AW-1:0];
               `SPL_REG_BASE_STACK:   cfg.base_stack <= host_req.wdata[`SPL_MEM_AW-1:0];
               `SPL_REG_STACK_PTR:    cfg.stack_ptr_addr <= host_req.wdata[`SPL_MEM_AW-1:0];
               default: ;
            endcase
         end
         if (enq_fire) num_enq <= num_enq + 1'b1;
         if (deq_fire) num_deq <= num_deq + 1'b1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // readback, one cycle after the strobe.
   always_ff @(posedge clk) begin
      if (!rstn) host_rvalid <= 1'b0;
      else host_rvalid <= host_valid & ~host_req.write;
   end

   always_ff @(posedge clk) begin
      if (host_valid && !host_req.write) begin
         rd_mem_q <= host_req.sel_mem;
         case (host_req.addr[7:0])
            `SPL_REG_START:   reg_rdata <= mem_word_t'(cfg.start) << core_id;
            `SPL_REG_NUM_ENQ: reg_rdata <= mem_word_t'(num_enq);
            `SPL_REG_NUM_DEQ: reg_rdata <= mem_word_t'(num_deq);
            `SPL_REG_STATE:   reg_rdata <= mem_word_t'(state);
            default:          reg_rdata <= '0;
         endcase
      end
   end

endmodule

// File: logic/spill_mem.sv
`timescale 1ns/1ps
`include "splitter_config.svh"

module spill_mem import splitter_pkg::*; (
   input  logic      clk,
   input  logic      rstn,

   input  logic      req_valid,
   output logic      req_ready,
   input  mem_req_t  req,
   output logic      rsp_valid,
   input  logic      rsp_ready,
   output mem_rsp_t  rsp,
   output logic      wr_ack,

   input  logic      host_en,
   input  logic      host_we,
   input  mem_addr_t host_addr,
   input  mem_word_t host_wdata,
   output mem_word_t host_rdata
);

   mem_word_t  mem [1 << `SPL_MEM_AW];
   mem_addr_t  rd_addr;
   logic [1:0] beats_left;
   mem_word_t  beat_data;
   logic       beat_last;
   logic       rd_start, rd_next, wr_en;

   assign req_ready = 1'b1;
   assign rd_start  = req_valid & req_ready & ~req.write;
   assign wr_en     = req_valid & req_ready & req.write;
   assign rd_next   = rsp_valid & rsp_ready & ~beat_last;
   assign rsp       = '{rdata: beat_data, rlast: beat_last};

   always_ff @(posedge clk) begin
      if (wr_en) mem[req.addr] <= req.wdata;
      if (host_en) begin
         if (host_we) mem[host_addr] <= host_wdata;
         else host_rdata <= mem[host_addr];
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // burst beat register.
   always_ff @(posedge clk) begin
      if (rd_start) begin
         rd_addr    <= req.addr;
         beats_left <= req.len;
         beat_data  <= mem[req.addr];
         beat_last  <= (req.len == 2'd0);
      end else if (rd_next) begin
         rd_addr    <= rd_addr + 1'b1;
         beats_left <= beats_left - 1'b1;
         beat_data  <= mem[rd_addr + 1'b1];
         beat_last  <= (beats_left == 2'd1);
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rsp_valid <= 1'b0;
         wr_ack    <= 1'b0;
      end else begin
         wr_ack <= wr_en;
         if (rd_start) rsp_valid <= 1'b1;
         else if (rsp_valid && rsp_ready && beat_last) rsp_valid <= 1'b0; // burst done.
      end
   end

endmodule

// File: splitter/splitter.sv
`timescale 1ns/1ps
`include "splitter_config.svh"

module splitter import splitter_pkg::*; (
   input  logic       clk,
   input  logic       rstn,
   input  cfg_t       cfg,

   input  logic       in_valid,
   output logic       in_ready,
   input  task_t      in_task,

   output logic       out_valid,
   input  logic       out_ready,
   output task_t      out_task,

   output logic       req_valid,
   input  logic       req_ready,
   output mem_req_t   req,
   input  logic       rsp_valid,
   output logic       rsp_ready,
   input  mem_rsp_t   rsp,
   input  logic       wr_ack,

   input  logic       lock_in,
   output logic       lock_out,
   output ts_t        lvt,
   output spl_state_t state,
   output logic       deq_fire,
   output logic       enq_fire
);

   localparam int PER_CHUNK = 1 << `SPL_LOG_PER_CHUNK;

   spl_state_t           state_next;
   coal_id_t             coal_id;
   task_t                child_task;
   logic                 child_last;
   logic [PER_CHUNK-1:0] bitmap;
   logic                 bitmap_full;
   mem_addr_t            stack_ptr;
   mem_addr_t            ptr_dec;

   assign in_ready    = (state == SPL_IDLE) & cfg.start & in_valid;
   assign deq_fire    = in_valid & in_ready;
   assign out_valid   = (state == SPL_ENQ_CHILD);
   assign out_task    = child_task; // held until taken.
   assign enq_fire    = out_valid & out_ready;
   assign bitmap_full = &bitmap;
   assign ptr_dec     = stack_ptr - 1'b1;

   always_comb begin
      case (state)
         SPL_WAIT_MEM, SPL_READ_SCRATCH_WAIT, SPL_READ_PTR_WAIT: rsp_ready = 1'b1;
         default: rsp_ready = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= SPL_IDLE;
         lvt   <= '1;
      end else begin
         state <= state_next;
         if (deq_fire) lvt <= in_task.ts;
         else if (state == SPL_IDLE) lvt <= '1;
      end
   end

   // datapath registers, qualified by state.
   always_ff @(posedge clk) begin
      if (deq_fire) coal_id <= in_task.locale[31:16];
      if (state == SPL_WAIT_MEM && rsp_valid) begin
         child_task <= rsp.rdata;
         child_last <= rsp.rlast;
      end
      if (state == SPL_READ_SCRATCH_WAIT && rsp_valid) begin
         bitmap <= rsp.rdata[PER_CHUNK-1:0] |
            (PER_CHUNK'(1) << coal_id[`SPL_LOG_PER_CHUNK-1:0]);
      end
      if (state == SPL_READ_PTR_WAIT && rsp_valid) stack_ptr <= rsp.rdata[`SPL_MEM_AW-1:0];
   end

   // splitter wins a tie with the coalescer.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         lock_out <= 1'b0;
      end else if (state == SPL_GRAB_LOCK && !lock_in) begin
         lock_out <= 1'b1;
      end else if (state == SPL_RELEASE_LOCK) begin
         lock_out <= 1'b0;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // next state and memory requests.
   always_comb begin
      state_next = state;
      req_valid  = 1'b0;
      req        = '0;
      case (state)
         SPL_IDLE: if (deq_fire) state_next = SPL_READ_MEM;
         SPL_READ_MEM: begin
            req_valid = 1'b1;
            req.addr  = cfg.base_tasks + mem_addr_t'(coal_id * `SPL_TASKS_PER_SPLITTER);
            req.len   = 2'(`SPL_TASKS_PER_SPLITTER - 1);
            if (req_ready) state_next = SPL_WAIT_MEM;
         end
         SPL_WAIT_MEM: if (rsp_valid) state_next = SPL_ENQ_CHILD;
         SPL_ENQ_CHILD: begin
            if (out_ready) state_next = child_last ? SPL_READ_SCRATCH : SPL_WAIT_MEM;
         end
         SPL_READ_SCRATCH: begin
            req_valid = 1'b1;
            req.addr  = cfg.base_scratch + mem_addr_t'(coal_id >> `SPL_LOG_PER_CHUNK);
            if (req_ready) state_next = SPL_READ_SCRATCH_WAIT;
         end
         SPL_READ_SCRATCH_WAIT: if (rsp_valid) state_next = SPL_WRITE_SCRATCH;
         SPL_WRITE_SCRATCH: begin
            req_valid = 1'b1;
            req.write = 1'b1;
            req.addr  = cfg.base_scratch + mem_addr_t'(coal_id >> `SPL_LOG_PER_CHUNK);
            req.wdata = bitmap_full ? '0 : mem_word_t'(bitmap); // full chunk starts over.
            if (req_ready) state_next = SPL_WRITE_SCRATCH_WAIT;
         end
         SPL_WRITE_SCRATCH_WAIT: begin
            if (wr_ack) state_next = bitmap_full ? SPL_GRAB_LOCK : SPL_IDLE;
         end
         SPL_GRAB_LOCK: if (!lock_in) state_next = SPL_READ_PTR;
         SPL_READ_PTR: begin
            req_valid = 1'b1;
            req.addr  = cfg.stack_ptr_addr;
            if (req_ready) state_next = SPL_READ_PTR_WAIT;
         end
         SPL_READ_PTR_WAIT: if (rsp_valid) state_next = SPL_WRITE_PTR;
         SPL_WRITE_PTR: begin
            req_valid = 1'b1;
            req.write = 1'b1;
            req.addr  = cfg.stack_ptr_addr;
            req.wdata = mem_word_t'(ptr_dec);
            if (req_ready) state_next = SPL_WRITE_PTR_WAIT;
         end
         SPL_WRITE_PTR_WAIT: if (wr_ack) state_next = SPL_WRITE_TOP;
         SPL_WRITE_TOP: begin
            req_valid = 1'b1;
            req.write = 1'b1;
            req.addr  = cfg.base_stack + ptr_dec;
            req.wdata = mem_word_t'(coal_id >> `SPL_LOG_PER_CHUNK); // chunk number.
            if (req_ready) state_next = SPL_WRITE_TOP_WAIT;
         end
         SPL_WRITE_TOP_WAIT: if (wr_ack) state_next = SPL_RELEASE_LOCK;
         SPL_RELEASE_LOCK: state_next = SPL_IDLE;
         default: state_next = SPL_IDLE;
      endcase
   end

endmodule

// File: common/splitter_pkg.sv
`include "splitter_config.svh"

package splitter_pkg;

   typedef logic [`SPL_MEM_AW-1:0] mem_addr_t;
   typedef logic [63:0]            mem_word_t;
   typedef logic [27:0]            ts_t;
   typedef logic [31:0]            locale_t;
   typedef logic [15:0]            coal_id_t; // upper half of a locale.

   typedef struct packed {
      logic [3:0] ttype;
      ts_t        ts;
      locale_t    locale;
   } task_t;

   typedef struct packed {
      logic       write;
      mem_addr_t  addr;
      logic [1:0] len; // beats minus one.
      mem_word_t  wdata;
   } mem_req_t;

   typedef struct packed {
      mem_word_t rdata;
      logic      rlast;
   } mem_rsp_t;

   typedef struct packed {
      logic      write;
      logic      sel_mem; // 1 selects spill memory.
      mem_addr_t addr;
      mem_word_t wdata;
   } host_req_t;

   typedef struct packed {
      logic      start;
      mem_addr_t base_tasks;
      mem_addr_t base_scratch;
      mem_addr_t base_stack;
      mem_addr_t stack_ptr_addr;
   } cfg_t;

   typedef enum logic [3:0] {
      SPL_IDLE, SPL_READ_MEM, SPL_WAIT_MEM, SPL_ENQ_CHILD,
      SPL_READ_SCRATCH, SPL_READ_SCRATCH_WAIT,
      SPL_WRITE_SCRATCH, SPL_WRITE_SCRATCH_WAIT,
      SPL_GRAB_LOCK, SPL_READ_PTR, SPL_READ_PTR_WAIT,
      SPL_WRITE_PTR, SPL_WRITE_PTR_WAIT,
      SPL_WRITE_TOP, SPL_WRITE_TOP_WAIT, SPL_RELEASE_LOCK
   } spl_state_t;

endpackage

// File: common/splitter_config.svh
`ifndef SPLITTER_CONFIG_SVH
`define SPLITTER_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~
// sizes.
`define SPL_MEM_AW             10 // word address bits of spill memory.
`define SPL_TASKS_PER_SPLITTER 4
`define SPL_LOG_PER_CHUNK      3  // 8 ids per scratchpad word.

// ~~~~~~~~~~~~~~~~~~~~
// host register offsets.
`define SPL_REG_START        8'h00
`define SPL_REG_BASE_TASKS   8'h04
`define SPL_REG_BASE_SCRATCH 8'h08
`define SPL_REG_BASE_STACK   8'h0c
`define SPL_REG_STACK_PTR    8'h10
`define SPL_REG_NUM_ENQ      8'h20
`define SPL_REG_NUM_DEQ      8'h24
`define SPL_REG_STATE        8'h28

`endif
